//--- source/cpu_pkg.sv
package cpu_pkg;

   localparam int data_w     = 32;
   localparam int reg_addr_w = 5;
   localparam int imm_w      = 16;
   localparam int apb_addr_w = 12;

   // Instruction fields
   localparam int op_msb  = 31;
   localparam int op_lsb  = 27;
   localparam int rd_msb  = 26;
   localparam int rd_lsb  = 22;
   localparam int rs1_msb = 21;
   localparam int rs1_lsb = 17;
   localparam int rs2_msb = 16;
   localparam int rs2_lsb = 12;
   localparam int imm_msb = imm_w - 1;
   localparam int imm_lsb = 0;

   // APB address map
   localparam logic [apb_addr_w-1:0] ctrl_addr       = 12'h000;
   localparam logic [apb_addr_w-1:0] mem_window_base = 12'h400;

   // ld rd takes word imm, st writes rs1 to word imm
   // jnz jumps to word imm when rs1 is nonzero
   typedef enum logic [4:0] {
      op_nop, op_ldi, op_add, op_sub, op_and, op_or, op_xor, op_shl,
      op_ld, op_st, op_jnz, op_halt
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_pass_b
   } alu_op_e;

endpackage

//--- source/alu.sv
`timescale 1ns/100ps

module alu (
   input  logic [cpu_pkg::data_w-1:0] a,
   input  logic [cpu_pkg::data_w-1:0] b,
   input  cpu_pkg::alu_op_e           op,
   output logic [cpu_pkg::data_w-1:0] y
);

   localparam int sh_w = $clog2(cpu_pkg::data_w);

   always_comb begin
      case (op)
         cpu_pkg::alu_add:    y = a + b;
         cpu_pkg::alu_sub:    y = a - b;
         cpu_pkg::alu_and:    y = a & b;
         cpu_pkg::alu_or:     y = a | b;
         cpu_pkg::alu_xor:    y = a ^ b;
         // Only the low bits of b count as shift distance
         cpu_pkg::alu_shl:    y = a << b[sh_w-1:0];
         cpu_pkg::alu_pass_b: y = b;
         default:             y = '0;
      endcase
   end

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cpu_pkg::reg_addr_w-1:0] raddr0,
   input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
   input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
   input  logic [cpu_pkg::data_w-1:0]     wdata,
   input  logic                           wen,
   output logic [cpu_pkg::data_w-1:0]     rdata0,
   output logic [cpu_pkg::data_w-1:0]     rdata1
);

   localparam int n_regs = 2 ** cpu_pkg::reg_addr_w;

   logic [cpu_pkg::data_w-1:0] regs [n_regs];
   logic                       wr_live;

   // r0 is never written
   assign wr_live = wen && waddr != '0;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < n_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[waddr] <= wdata;
      end
   end

   // Write-through so decode sees the write-back value in the same cycle
   assign rdata0 = (wr_live && waddr == raddr0) ? wdata : regs[raddr0];
   assign rdata1 = (wr_live && waddr == raddr1) ? wdata : regs[raddr1];

   r0_stays_zero: assert property (@(posedge clk) disable iff (!rst) wen |=> regs[0] == '0)
      else $error("r0 changed after a register write");

endmodule

//--- source/decoder.sv
`timescale 1ns/100ps

module decoder (
   input  logic [cpu_pkg::data_w-1:0]     instr,
   output cpu_pkg::opcode_e               opcode,
   output logic [cpu_pkg::reg_addr_w-1:0] rd,
   output logic [cpu_pkg::reg_addr_w-1:0] rs1,
   output logic [cpu_pkg::reg_addr_w-1:0] rs2,
   output logic [cpu_pkg::data_w-1:0]     imm,
   output cpu_pkg::alu_op_e               alu_op,
   output logic                           uses_rs1,
   output logic                           uses_rs2,
   output logic                           reg_write,
   output logic                           mem_read,
   output logic                           mem_write,
   output logic                           is_jump,
   output logic                           is_halt
);

   cpu_pkg::opcode_e raw_op;
   logic             reg_op;

   assign raw_op = cpu_pkg::opcode_e'(instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
   assign rd     = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
   assign rs1    = instr[cpu_pkg::rs1_msb:cpu_pkg::rs1_lsb];
   assign rs2    = instr[cpu_pkg::rs2_msb:cpu_pkg::rs2_lsb];
   assign imm    = {{(cpu_pkg::data_w - cpu_pkg::imm_w){1'b0}},
                    instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]};

   // Unknown opcodes behave as nop
   assign opcode = (raw_op <= cpu_pkg::op_halt) ? raw_op : cpu_pkg::op_nop;

   // Register to register operations
   assign reg_op = raw_op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
                                  cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_shl};

   assign uses_rs1  = reg_op || raw_op inside {cpu_pkg::op_st, cpu_pkg::op_jnz};
   assign uses_rs2  = reg_op;
   assign reg_write = reg_op || raw_op inside {cpu_pkg::op_ldi, cpu_pkg::op_ld};
   assign mem_read  = raw_op == cpu_pkg::op_ld;
   assign mem_write = raw_op == cpu_pkg::op_st;
   assign is_jump   = raw_op == cpu_pkg::op_jnz;
   assign is_halt   = raw_op == cpu_pkg::op_halt;

   // ldi, ld and st send the immediate straight through
   always_comb begin
      case (raw_op)
         cpu_pkg::op_add: alu_op = cpu_pkg::alu_add;
         cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
         cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
         cpu_pkg::op_or:  alu_op = cpu_pkg::alu_or;
         cpu_pkg::op_xor: alu_op = cpu_pkg::alu_xor;
         cpu_pkg::op_shl: alu_op = cpu_pkg::alu_shl;
         default:         alu_op = cpu_pkg::alu_pass_b;
      endcase
   end

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
   input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
   input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
   input  logic                           uses_rs1,
   input  logic                           uses_rs2,
   input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
   input  logic                           ex_reg_write,
   input  logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
   input  logic                           mem_reg_write,
   output logic                           stall
);

   logic rs1_busy;
   logic rs2_busy;

   // r0 never carries a dependency
   assign rs1_busy = uses_rs1 && rs1 != '0 &&
                     ((ex_reg_write && ex_rd == rs1) || (mem_reg_write && mem_rd == rs1));
   assign rs2_busy = uses_rs2 && rs2 != '0 &&
                     ((ex_reg_write && ex_rd == rs2) || (mem_reg_write && mem_rd == rs2));

   // Producers in write-back are covered by the register file write-through
   assign stall = rs1_busy || rs2_busy;

   stall_known: assert final (!$isunknown(stall))
      else $error("Stall is unknown");

endmodule

//--- source/unified_memory.sv
`timescale 1ns/100ps

module unified_memory #(
   parameter int depth = 256
) (
   input  logic                       clk,
   input  logic                       rd_en0,
   input  logic [$clog2(depth)-1:0]   addr0,
   input  logic [$clog2(depth)-1:0]   addr1,
   input  logic [cpu_pkg::data_w-1:0] wdata1,
   input  logic                       wen1,
   output logic [cpu_pkg::data_w-1:0] rdata0,
   output logic [cpu_pkg::data_w-1:0] rdata1
);

   // Powers up cleared
   logic [cpu_pkg::data_w-1:0] mem [depth] = '{default: '0};

   // Instruction port holds its word while fetch is held
   always_ff @(posedge clk) begin
      if (rd_en0) begin
         rdata0 <= mem[addr0];
      end
   end

   // Data port is read-before-write
   always_ff @(posedge clk) begin
      if (wen1) begin
         mem[addr1] <= wdata1;
      end
      rdata1 <= mem[addr1];
   end

endmodule

//--- source/apb_host_port.sv
`timescale 1ns/100ps

module apb_host_port #(
   parameter int depth = 256
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cpu_pkg::apb_addr_w-1:0] paddr,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [cpu_pkg::data_w-1:0]     pwdata,
   input  logic                           halt_done,
   input  logic [$clog2(depth)-1:0]       core_addr,
   input  logic [cpu_pkg::data_w-1:0]     core_wdata,
   input  logic                           core_wen,
   input  logic [cpu_pkg::data_w-1:0]     mem_rdata,
   output logic [cpu_pkg::data_w-1:0]     prdata,
   output logic                           pready,
   output logic                           pslverr,
   output logic                           running,
   output logic                           start,
   output logic [$clog2(depth)-1:0]       mem_addr,
   output logic [cpu_pkg::data_w-1:0]     mem_wdata,
   output logic                           mem_wen
);

   logic [cpu_pkg::apb_addr_w:0] offset;
   logic access, ctrl_hit, mem_hit, need_wait, rd_wait;

   assign access   = psel && penable;
   // Addresses below the window wrap to a large offset and miss
   assign offset   = {1'b0, paddr} - {1'b0, cpu_pkg::mem_window_base};
   assign ctrl_hit = paddr == cpu_pkg::ctrl_addr;
   assign mem_hit  = paddr[1:0] == 2'b00 && offset[cpu_pkg::apb_addr_w:2] < depth;

   // Memory reads wait one cycle for the synchronous port
   assign need_wait = mem_hit && !pwrite && !running;
   assign pready    = access && (!need_wait || rd_wait);
   assign pslverr   = pready && (!(ctrl_hit || mem_hit) || (mem_hit && running));
   assign start     = access && pwrite && ctrl_hit && pwdata[0] && !running;

   always_comb begin
      if (ctrl_hit) begin
         prdata = {{(cpu_pkg::data_w - 1){1'b0}}, running};
      end else if (mem_hit && !running) begin
         prdata = mem_rdata;
      end else begin
         prdata = '0;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         running <= 1'b0;
         rd_wait <= 1'b0;
      end else begin
         rd_wait <= access && need_wait && !rd_wait;
         if (start) begin
            running <= 1'b1;
         end else if (halt_done) begin
            running <= 1'b0;
         end
      end
   end

   // Port 1 belongs to the host only while the core is stopped
   assign mem_addr  = running ? core_addr : offset[$clog2(depth)+1:2];
   assign mem_wdata = running ? core_wdata : pwdata;
   assign mem_wen   = running ? core_wen : (access && pwrite && mem_hit);

   paddr_stable: assert property (@(posedge clk) disable iff (!rst)
      psel && !(penable && pready) |=> $stable(paddr))
      else $error("paddr changed before the transfer completed");

endmodule

//--- source/cpu_pipelined.sv
`timescale 1ns/100ps

module cpu_pipelined #(
   parameter int depth = 256
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cpu_pkg::apb_addr_w-1:0] paddr,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [cpu_pkg::data_w-1:0]     pwdata,
   output logic [cpu_pkg::data_w-1:0]     prdata,
   output logic                           pready,
   output logic                           pslverr
);

   localparam int addr_w = $clog2(depth);

   logic running, start, halt_done;

   // Fetch
   logic [addr_w-1:0]          pc;
   logic                       fetch_en, id_valid;
   logic [cpu_pkg::data_w-1:0] if_instr;

   // Decode
   cpu_pkg::opcode_e                 id_opcode;
   cpu_pkg::alu_op_e                 id_alu_op;
   logic [cpu_pkg::reg_addr_w-1:0]   id_rd, id_rs1, id_rs2;
   logic [cpu_pkg::data_w-1:0]       id_imm, rs1_val, rs2_val;
   logic id_uses_rs1, id_uses_rs2, id_reg_write, id_mem_read, id_mem_write;
   logic id_is_jump, id_is_halt, stall;

   // ID/EX
   logic id_ex_valid, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
   logic id_ex_is_jump, id_ex_is_halt;
   logic [cpu_pkg::reg_addr_w-1:0] id_ex_rd;
   cpu_pkg::alu_op_e               id_ex_alu_op;
   logic [cpu_pkg::data_w-1:0]     id_ex_a, id_ex_b, alu_y;
   logic                           flush;

   // EX/MEM and MEM/WB
   logic ex_mem_valid, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_is_halt;
   logic [cpu_pkg::reg_addr_w-1:0] ex_mem_rd, mem_wb_rd;
   logic [cpu_pkg::data_w-1:0]     ex_mem_result, ex_mem_store, mem_wb_result, wb_data;
   logic mem_wb_valid, mem_wb_reg_write, mem_wb_mem_read, mem_wb_is_halt;

   // Data port
   logic [addr_w-1:0]          mem_addr;
   logic [cpu_pkg::data_w-1:0] mem_wdata, mem_rdata;
   logic                       mem_wen;

   // Fetch control, a redirect from execute beats a stall
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pc       <= '0;
         fetch_en <= 1'b0;
         id_valid <= 1'b0;
      end else if (start) begin
         pc       <= '0;
         fetch_en <= 1'b1;
         id_valid <= 1'b0;
      end else if (flush) begin
         pc       <= id_ex_b[addr_w-1:0];
         fetch_en <= fetch_en && !id_ex_is_halt;
         id_valid <= 1'b0;
      end else if (!stall) begin
         if (fetch_en) begin
            pc <= pc + 1'b1;
         end
         id_valid <= fetch_en;
      end
   end

   decoder u_decoder (
      .instr(if_instr), .opcode(id_opcode), .rd(id_rd), .rs1(id_rs1), .rs2(id_rs2),
      .imm(id_imm), .alu_op(id_alu_op), .uses_rs1(id_uses_rs1), .uses_rs2(id_uses_rs2),
      .reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
      .is_jump(id_is_jump), .is_halt(id_is_halt)
   );

   register_file u_register_file (
      .clk(clk), .rst(rst), .raddr0(id_rs1), .raddr1(id_rs2),
      .waddr(mem_wb_rd), .wdata(wb_data), .wen(mem_wb_valid && mem_wb_reg_write),
      .rdata0(rs1_val), .rdata1(rs2_val)
   );

   hazard_unit u_hazard_unit (
      .rs1(id_rs1), .rs2(id_rs2),
      .uses_rs1(id_valid && id_uses_rs1), .uses_rs2(id_valid && id_uses_rs2),
      .ex_rd(id_ex_rd), .ex_reg_write(id_ex_valid && id_ex_reg_write),
      .mem_rd(ex_mem_rd), .mem_reg_write(ex_mem_valid && ex_mem_reg_write),
      .stall(stall)
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         id_ex_valid  <= 1'b0;
         ex_mem_valid <= 1'b0;
         mem_wb_valid <= 1'b0;
      end else begin
         // Stalled, squashed and nop slots go on as bubbles
         id_ex_valid  <= id_valid && id_opcode != cpu_pkg::op_nop && !stall && !flush;
         ex_mem_valid <= id_ex_valid;
         mem_wb_valid <= ex_mem_valid;
      end
   end

   always_ff @(posedge clk) begin
      id_ex_rd         <= id_rd;
      id_ex_alu_op     <= id_alu_op;
      id_ex_reg_write  <= id_reg_write;
      id_ex_mem_read   <= id_mem_read;
      id_ex_mem_write  <= id_mem_write;
      id_ex_is_jump    <= id_is_jump;
      id_ex_is_halt    <= id_is_halt;
      id_ex_a          <= rs1_val;
      // Immediate doubles as jump target and memory word
      id_ex_b          <= id_uses_rs2 ? rs2_val : id_imm;
      ex_mem_rd        <= id_ex_rd;
      ex_mem_reg_write <= id_ex_reg_write;
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_is_halt   <= id_ex_is_halt;
      ex_mem_result    <= alu_y;
      ex_mem_store     <= id_ex_a;
      mem_wb_rd        <= ex_mem_rd;
      mem_wb_reg_write <= ex_mem_reg_write;
      mem_wb_mem_read  <= ex_mem_mem_read;
      mem_wb_is_halt   <= ex_mem_is_halt;
      mem_wb_result    <= ex_mem_result;
   end

   alu u_alu (.a(id_ex_a), .b(id_ex_b), .op(id_ex_alu_op), .y(alu_y));

   // Taken jnz or halt squashes the two younger slots
   assign flush = id_ex_valid && ((id_ex_is_jump && id_ex_a != '0) || id_ex_is_halt);

   // Load data arrives from the synchronous port during write-back
   assign wb_data   = mem_wb_mem_read ? mem_rdata : mem_wb_result;
   assign halt_done = mem_wb_valid && mem_wb_is_halt;

   unified_memory #(.depth(depth)) u_unified_memory (
      .clk(clk), .rd_en0(running && !stall), .addr0(pc), .addr1(mem_addr),
      .wdata1(mem_wdata), .wen1(mem_wen), .rdata0(if_instr), .rdata1(mem_rdata)
   );

   apb_host_port #(.depth(depth)) u_apb_host_port (
      .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .halt_done(halt_done),
      .core_addr(ex_mem_result[addr_w-1:0]), .core_wdata(ex_mem_store),
      .core_wen(ex_mem_valid && ex_mem_mem_write), .mem_rdata(mem_rdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .running(running),
      .start(start), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wen(mem_wen)
   );

   flush_redirects_pc: assert property (@(posedge clk) disable iff (!rst)
      flush |=> pc == $past(id_ex_b[addr_w-1:0]))
      else $error("PC did not take the flush target");

endmodule

//--- tb/tb_cpu_pipelined.sv
`timescale 1ns/100ps

module tb_cpu_pipelined;

   localparam int n_rows       = 8;
   localparam int row_cycles   = 400;
   localparam int cycle_limit  = n_rows * row_cycles;
   localparam int result_word  = 'h80;
   localparam int marker_word  = 'h84;
   localparam int load_word    = 'h90;
   localparam int guarded_word = 'ha0;

   typedef enum {kind_alu, kind_load, kind_jump} kind_e;

   logic        clk;
   logic        rst;
   logic [11:0] paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   cpu_pkg::opcode_e row_op [n_rows];
   kind_e            row_kind [n_rows];
   logic [31:0]      row_a [n_rows];
   logic [31:0]      row_b [n_rows];
   logic [31:0]      prog [$];
   logic [31:0]      rd_val;
   int               cycles;

   cpu_pipelined #(.depth(256)) dut0 (
      .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout: the run went past %0d clock cycles", cycle_limit);
         $display("=== FAIL ===");
         $fatal(1, "Simulation stopped by the cycle limit");
      end
   end

   task automatic check(input logic [31:0] actual, input logic [31:0] exp_val,
                        input string what);
      if (actual !== exp_val) begin
         $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, exp_val);
         $display("=== FAIL ===");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // One APB transfer, outputs sampled on the falling edge
   task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      @(posedge clk);
      #1;
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (!pready) begin
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic exp_err);
      logic [31:0] unused;
      logic        err;
      apb_transfer(1'b1, addr, data, unused, err);
      check(32'(err), 32'(exp_err), $sformatf("pslverr on write to %h", addr));
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                           input logic exp_err);
      logic err;
      apb_transfer(1'b0, addr, 32'h0, data, err);
      check(32'(err), 32'(exp_err), $sformatf("pslverr on read from %h", addr));
   endtask

   function automatic logic [11:0] word_addr(input int word);
      return cpu_pkg::mem_window_base + 12'(4 * word);
   endfunction

   // rs2 and imm16 overlap, so callers give one of them
   function automatic logic [31:0] assemble(input cpu_pkg::opcode_e op, input int rd,
                                            input int rs1, input int rs2, input int imm);
      logic [31:0] w;
      w = '0;
      w[cpu_pkg::imm_msb:cpu_pkg::imm_lsb] = 16'(imm);
      w[cpu_pkg::rs2_msb:cpu_pkg::rs2_lsb] = w[cpu_pkg::rs2_msb:cpu_pkg::rs2_lsb] | 5'(rs2);
      w[cpu_pkg::rs1_msb:cpu_pkg::rs1_lsb] = 5'(rs1);
      w[cpu_pkg::rd_msb:cpu_pkg::rd_lsb]   = 5'(rd);
      w[cpu_pkg::op_msb:cpu_pkg::op_lsb]   = op;
      return w;
   endfunction

   function automatic logic [31:0] alu_rule(input cpu_pkg::opcode_e op,
                                            input logic [31:0] a, input logic [31:0] b);
      case (op)
         cpu_pkg::op_add: return a + b;
         cpu_pkg::op_sub: return a - b;
         cpu_pkg::op_and: return a & b;
         cpu_pkg::op_or:  return a | b;
         cpu_pkg::op_xor: return a ^ b;
         cpu_pkg::op_shl: return a << b[4:0];
         default:         return 32'h0;
      endcase
   endfunction

   // Load the program, start the core and poll until it stops
   task automatic run_program();
      for (int i = 0; i < prog.size(); i++) begin
         apb_write(word_addr(i), prog[i], 1'b0);
      end
      apb_write(cpu_pkg::ctrl_addr, 32'h1, 1'b0);
      do begin
         apb_read(cpu_pkg::ctrl_addr, rd_val, 1'b0);
      end while (rd_val[0]);
   endtask

   task automatic set_row(input int i, input cpu_pkg::opcode_e op, input kind_e kind);
      row_op[i]   = op;
      row_kind[i] = kind;
      row_a[i]    = $urandom & 32'hffff;
      row_b[i]    = $urandom & 32'hffff;
      if (kind == kind_load) begin
         row_a[i] = $urandom;
      end else if (kind == kind_jump) begin
         row_a[i] = 2 + $urandom % 14;
      end
   endtask

   task automatic run_row(input int i);
      logic [31:0] a;
      logic [31:0] exp_val;
      logic [31:0] marker;
      a      = row_a[i];
      marker = 32'hc0de_0000 + i;
      prog.delete();
      if (row_kind[i] == kind_alu) begin
         exp_val = alu_rule(row_op[i], a, row_b[i]);
         prog.push_back(assemble(cpu_pkg::op_ldi, 1, 0, 0, a));
         prog.push_back(assemble(cpu_pkg::op_ldi, 2, 0, 0, row_b[i]));
         prog.push_back(assemble(row_op[i], 3, 1, 2, 0));
         prog.push_back(assemble(cpu_pkg::op_st, 0, 3, 0, result_word));
      end else if (row_kind[i] == kind_load) begin
         exp_val = a + a;
         apb_write(word_addr(load_word), a, 1'b0);
         prog.push_back(assemble(cpu_pkg::op_ld, 4, 0, 0, load_word));
         prog.push_back(assemble(cpu_pkg::op_add, 5, 4, 4, 0));
         prog.push_back(assemble(cpu_pkg::op_st, 0, 5, 0, result_word));
      end else begin
         // Countdown in r1, addend in r2, sum in r6
         exp_val = a * a;
         apb_write(word_addr(marker_word), marker, 1'b0);
         prog.push_back(assemble(cpu_pkg::op_ldi, 1, 0, 0, a));
         prog.push_back(assemble(cpu_pkg::op_ldi, 2, 0, 0, a));
         prog.push_back(assemble(cpu_pkg::op_ldi, 3, 0, 0, 1));
         prog.push_back(assemble(cpu_pkg::op_ldi, 6, 0, 0, 0));
         prog.push_back(assemble(cpu_pkg::op_add, 6, 6, 2, 0));
         prog.push_back(assemble(cpu_pkg::op_sub, 1, 1, 3, 0));
         prog.push_back(assemble(cpu_pkg::op_jnz, 0, 1, 0, 4));
         // r3 is 1, so this jnz always skips the two marker stores in its shadow
         prog.push_back(assemble(cpu_pkg::op_jnz, 0, 3, 0, 10));
         prog.push_back(assemble(cpu_pkg::op_st, 0, 2, 0, marker_word));
         prog.push_back(assemble(cpu_pkg::op_st, 0, 2, 0, marker_word));
         prog.push_back(assemble(cpu_pkg::op_st, 0, 6, 0, result_word));
      end
      prog.push_back(assemble(cpu_pkg::op_halt, 0, 0, 0, 0));
      // Squashed by the halt
      prog.push_back(assemble(cpu_pkg::op_st, 0, 2, 0, marker_word));
      prog.push_back(assemble(cpu_pkg::op_st, 0, 2, 0, marker_word));
      apb_write(word_addr(result_word), ~exp_val, 1'b0);
      run_program();
      apb_read(word_addr(result_word), rd_val, 1'b0);
      check(rd_val, exp_val, $sformatf("row %0d result, %s", i, row_op[i].name()));
      if (row_kind[i] == kind_jump) begin
         apb_read(word_addr(marker_word), rd_val, 1'b0);
         check(rd_val, marker, "marker word after the jump loop");
      end
   endtask

   initial begin
      rst     = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      cycles  = 0;
      void'($urandom(32'h581e8433));
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b1;

      apb_read(cpu_pkg::ctrl_addr, rd_val, 1'b0);
      check(rd_val, 32'h0, "status after reset");
      apb_read(word_addr(0), rd_val, 1'b0);
      check(rd_val, 32'h0, "word 0 after reset");
      apb_read(12'h010, rd_val, 1'b1);

      set_row(0, cpu_pkg::op_add, kind_alu);
      set_row(1, cpu_pkg::op_sub, kind_alu);
      set_row(2, cpu_pkg::op_and, kind_alu);
      set_row(3, cpu_pkg::op_or, kind_alu);
      set_row(4, cpu_pkg::op_xor, kind_alu);
      set_row(5, cpu_pkg::op_shl, kind_alu);
      set_row(6, cpu_pkg::op_ld, kind_load);
      set_row(7, cpu_pkg::op_jnz, kind_jump);
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end

      // Host memory write is refused while a long loop runs
      apb_write(word_addr(guarded_word), 32'h1234_5678, 1'b0);
      prog.delete();
      prog.push_back(assemble(cpu_pkg::op_ldi, 1, 0, 0, 24));
      prog.push_back(assemble(cpu_pkg::op_ldi, 2, 0, 0, 1));
      prog.push_back(assemble(cpu_pkg::op_sub, 1, 1, 2, 0));
      prog.push_back(assemble(cpu_pkg::op_jnz, 0, 1, 0, 2));
      prog.push_back(assemble(cpu_pkg::op_halt, 0, 0, 0, 0));
      for (int i = 0; i < prog.size(); i++) begin
         apb_write(word_addr(i), prog[i], 1'b0);
      end
      apb_write(cpu_pkg::ctrl_addr, 32'h1, 1'b0);
      apb_read(cpu_pkg::ctrl_addr, rd_val, 1'b0);
      check(rd_val, 32'h1, "status while the loop runs");
      apb_write(word_addr(guarded_word), 32'hedcb_a987, 1'b1);
      do begin
         apb_read(cpu_pkg::ctrl_addr, rd_val, 1'b0);
      end while (rd_val[0]);
      apb_read(word_addr(guarded_word), rd_val, 1'b0);
      check(rd_val, 32'h1234_5678, "word written while running");

      // r0 stays zero
      prog.delete();
      prog.push_back(assemble(cpu_pkg::op_ldi, 0, 0, 0, 16'hbeef));
      prog.push_back(assemble(cpu_pkg::op_st, 0, 0, 0, result_word));
      prog.push_back(assemble(cpu_pkg::op_halt, 0, 0, 0, 0));
      apb_write(word_addr(result_word), 32'hffff_ffff, 1'b0);
      run_program();
      apb_read(word_addr(result_word), rd_val, 1'b0);
      check(rd_val, 32'h0, "store of r0 after a write to r0");

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- verilog.f
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/decoder.sv
source/hazard_unit.sv
source/unified_memory.sv
source/apb_host_port.sv
source/cpu_pipelined.sv
tb/tb_cpu_pipelined.sv
